//--- filelist.f
nnPkg.sv
neuronNode.sv
denseLayer.sv
argmaxSelect.sv
nnClassifier.sv
nnClassifier_properties.sv
tbNnClassifier.sv

//--- run.sh
#!/bin/sh
# Compile and run the classifier testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tbNnClassifier \
	-f filelist.f

simOut=$(./obj_dir/VtbNnClassifier 2>&1) || true
printf '%s\n' "$simOut"

if printf '%s\n' "$simOut" | grep -q '^>>> PASS$'; then
	exit 0
fi

echo "Simulation did not report a pass"
exit 1

//--- tbNnClassifier.sv
`timescale 1ns/1ps

module tbNnClassifier;
	import nnPkg::*;

	localparam int          CLK_PERIOD     = 8;
	localparam int          RESET_CYCLES   = 10;
	localparam int          DRAIN_LIMIT    = 20;  // Cycles allowed for the pipeline to empty
	localparam int          BURST_LEN      = 200;
	localparam int          RANDOM_LEN     = 100;
	localparam int          RESULT_LATENCY = 2 * NODE_LATENCY + 1; // Two layers and arg-max
	localparam logic [31:0] LFSR_SEED      = 32'h7ee4_9c60;
	localparam int          TEST_CYCLES    = RESET_CYCLES + 8 * (DRAIN_LIMIT + 1)
		+ BURST_LEN + RANDOM_LEN + DRAIN_LIMIT;

	logic        clk = 1'b0;
	logic        reset;
	featureVec_t features;
	logic        sampleStrobe;
	classIdx_t   classIdx;
	sample_t     classScore;
	logic        resultValid;

	logic [31:0] lfsrState;
	classIdx_t   expIdx[$];    // Expected results in sample order
	sample_t     expScore[$];
	int          expDue[$];    // Cycle in which each result must appear
	int          cycleCount;
	int          valueErrors;
	int          otherErrors;
	int          checkedCount;
	int          sentCount;

	nnClassifier u_nnClassifier (
		.clk          (clk),
		.reset        (reset),
		.features     (features),
		.sampleStrobe (sampleStrobe),
		.classIdx     (classIdx),
		.classScore   (classScore),
		.resultValid  (resultValid)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk)
	begin
		cycleCount++;
	end

	// ------------------------------------------------------------------------
	// Random numbers
	// ------------------------------------------------------------------------
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0]; // x^32+x^22+x^2+x+1
		return {state[30:0], feedback};
	endfunction

	function automatic logic [31:0] takeBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int b = 0; b < count; b++)
		begin
			lfsrState = lfsrNext(lfsrState);
			value     = {value[30:0], lfsrState[0]};
		end
		return value;
	endfunction

	function automatic featureVec_t randomFeatures();
		featureVec_t vec;
		for (int i = 0; i < NUM_FEATURES; i++)
		begin
			vec[i] = sample_t'(takeBits(DATA_W));
		end
		return vec;
	endfunction

	// ------------------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------------------
	function automatic void runModel(input featureVec_t f, output classIdx_t idx,
		output sample_t score, output logic tie);
		hiddenVec_t         hid;
		classVec_t          outs;
		sample_t            a;
		sample_t            w;
		logic signed [15:0] wide;
		logic [7:0]         acc;
		for (int n = 0; n < NUM_HIDDEN; n++)
		begin
			acc = HIDDEN_BIAS[n];
			for (int i = 0; i < NUM_FEATURES; i++)
			begin
				a    = f[i];
				w    = HIDDEN_WEIGHTS[n][i];
				wide = a * w;
				acc  = acc + wide[7:0];  // Only the low byte of each product counts
			end
			hid[n] = acc[7] ? sample_t'(0) : sample_t'(acc); // ReLU
		end
		for (int c = 0; c < NUM_CLASSES; c++)
		begin
			acc = OUTPUT_BIAS[c];
			for (int n = 0; n < NUM_HIDDEN; n++)
			begin
				a    = hid[n];
				w    = OUTPUT_WEIGHTS[c][n];
				wide = a * w;
				acc  = acc + wide[7:0];
			end
			outs[c] = sample_t'(acc);
		end
		idx   = '0;
		score = outs[0];
		tie   = 1'b0;
		for (int c = 1; c < NUM_CLASSES; c++)
		begin
			a = outs[c];
			if (a > score)
			begin
				idx   = classIdx_t'(c);
				score = a;
				tie   = 1'b0;
			end
			else if (a == score)
			begin
				tie = 1'b1;
			end
		end
	endfunction

	// First single-feature vector whose top two class scores are equal
	function automatic void findTieVector(output featureVec_t vec, output logic found);
		classIdx_t idx;
		sample_t   score;
		logic      tie;
		found = 1'b0;
		for (int k = 0; k < NUM_FEATURES; k++)
		begin
			for (int x = -128; x < 128; x++)
			begin
				vec    = '0;
				vec[k] = sample_t'(x);
				runModel(vec, idx, score, tie);
				if (tie)
				begin
					found = 1'b1;
					return;
				end
			end
		end
		for (int t = 0; t < 4096; t++)  // Fall back to random vectors
		begin
			vec = randomFeatures();
			runModel(vec, idx, score, tie);
			if (tie)
			begin
				found = 1'b1;
				return;
			end
		end
	endfunction

	// ------------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------------
	task automatic driveSample(input featureVec_t vec, input logic strobe);
		classIdx_t idx;
		sample_t   score;
		logic      tie;
		@(posedge clk);
		#1;
		features     = vec;
		sampleStrobe = strobe;
		if (strobe)
		begin
			runModel(vec, idx, score, tie);
			expIdx.push_back(idx);
			expScore.push_back(score);
			expDue.push_back(cycleCount + RESULT_LATENCY);
			sentCount++;
		end
	endtask

	task automatic waitForResults();
		int cycles;
		cycles = 0;
		@(posedge clk);
		#1;
		sampleStrobe = 1'b0;
		while (expIdx.size() != 0 && cycles < DRAIN_LIMIT)
		begin
			@(posedge clk);
			cycles++;
		end
		if (expIdx.size() != 0)
		begin
			$display("Missing results: %0d samples never produced resultValid",
				expIdx.size());
			otherErrors++;
			expIdx.delete();
			expScore.delete();
			expDue.delete();
		end
	endtask

	// Outputs are compared in the middle of the cycle
	always @(negedge clk)
	begin
		classIdx_t wantIdx;
		sample_t   wantScore;
		int        wantDue;
		if (reset)
		begin
			assert (!resultValid)
			else
			begin
				$display("** Error: resultValid expected %h got %h during reset",
					1'b0, resultValid);
				valueErrors++;
			end
		end
		else if (resultValid)
		begin
			if (expIdx.size() == 0)
			begin
				$display("Unexpected result: resultValid high with no sample outstanding");
				otherErrors++;
			end
			else
			begin
				wantIdx   = expIdx.pop_front();
				wantScore = expScore.pop_front();
				wantDue   = expDue.pop_front();
				checkedCount++;
				assert (cycleCount == wantDue)
				else
				begin
					$display("Result arrived in cycle %0d instead of cycle %0d",
						cycleCount, wantDue);
					otherErrors++;
				end
				assert (classIdx == wantIdx)
				else
				begin
					$display("** Error: classIdx expected %h got %h", wantIdx, classIdx);
					valueErrors++;
				end
				assert (classScore == wantScore)
				else
				begin
					$display("** Error: classScore expected %h got %h", wantScore, classScore);
					valueErrors++;
				end
			end
		end
	end

	// ------------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------------
	initial
	begin
		featureVec_t vec;
		logic        found;
		reset        = 1'b1;
		features     = '0;
		sampleStrobe = 1'b0;
		lfsrState    = LFSR_SEED;
		cycleCount   = 0;
		valueErrors  = 0;
		otherErrors  = 0;
		checkedCount = 0;
		sentCount    = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
		repeat (2 * NODE_LATENCY + 3) @(posedge clk); // Quiet pipeline after reset

		driveSample('0, 1'b1);  // Output biases alone decide the class
		waitForResults();

		vec    = '0;
		vec[2] = 8'sd1;         // Weight -84 pushes hidden neuron 0 below zero
		driveSample(vec, 1'b1);
		waitForResults();

		for (int i = 0; i < NUM_FEATURES; i++)
		begin
			vec[i] = 8'sd127;
		end
		driveSample(vec, 1'b1);
		for (int i = 0; i < NUM_FEATURES; i++)
		begin
			vec[i] = -8'sd128;
		end
		driveSample(vec, 1'b1);
		for (int i = 0; i < NUM_FEATURES; i++)
		begin
			vec[i] = (i % 2 == 0) ? 8'sd127 : -8'sd128;
		end
		driveSample(vec, 1'b1);
		waitForResults();

		findTieVector(vec, found);
		if (!found)
		begin
			$display("No feature vector with tied class scores was found");
			otherErrors++;
		end
		else
		begin
			driveSample(vec, 1'b1);
			waitForResults();
		end

		for (int s = 0; s < BURST_LEN; s++)
		begin
			driveSample(randomFeatures(), 1'b1);
		end
		for (int s = 0; s < RANDOM_LEN; s++)
		begin
			vec = randomFeatures();
			driveSample(vec, takeBits(1) == 32'd1);
		end
		waitForResults();

		$display("Checked %0d of %0d results: %0d value errors, %0d other errors",
			checkedCount, sentCount, valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0 && checkedCount == sentCount)
		begin
			$display(">>> PASS");
		end
		else
		begin
			$display(">>> FAIL");
		end
		$finish;
	end

	initial
	begin
		#((TEST_CYCLES + 100) * CLK_PERIOD);
		otherErrors++;
		$display("Watchdog expired: the run did not finish within %0d cycles",
			TEST_CYCLES + 100);
		$display("Checked %0d of %0d results: %0d value errors, %0d other errors",
			checkedCount, sentCount, valueErrors, otherErrors);
		$display(">>> FAIL");
		$finish;
	end

endmodule

//--- nnClassifier_properties.sv
`timescale 1ns/1ps

module nnClassifier_properties (
	input logic             clk,
	input logic             reset,
	input logic             sampleStrobe,
	input logic             resultValid,
	input nnPkg::classIdx_t classIdx
);
	import nnPkg::*;

	// Two dense layers plus the arg-max register
	localparam int PIPE_DEPTH = 2 * NODE_LATENCY + 1;

	logic [3:0] sinceReset; // Saturating count of cycles out of reset

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sinceReset <= '0;
		end
		else if (sinceReset != 4'hF)
		begin
			sinceReset <= sinceReset + 4'd1;
		end
	end

	// ------------------------------------------------------------------------
	// Reset behavior
	// ------------------------------------------------------------------------
	resetClearsValid: assert property (
		@(posedge clk) reset |=> !resultValid
	)
	else $error("resultValid high after a reset cycle");

	quietAfterReset: assert property (
		@(posedge clk) disable iff (reset)
		(sinceReset < PIPE_DEPTH) |-> !resultValid
	)
	else $error("resultValid high within seven cycles of reset release");

	// ------------------------------------------------------------------------
	// Strobe timing and index range
	// ------------------------------------------------------------------------
	validFollowsStrobe: assert property (
		@(posedge clk) disable iff (reset)
		(sinceReset >= PIPE_DEPTH) |-> (resultValid == $past(sampleStrobe, PIPE_DEPTH))
	)
	else $error("resultValid is not sampleStrobe delayed by seven cycles");

	idxInRange: assert property (
		@(posedge clk) disable iff (reset)
		resultValid |-> (classIdx < NUM_CLASSES)
	)
	else $error("classIdx out of range while resultValid is high");

endmodule

bind nnClassifier nnClassifier_properties u_properties (
	.clk          (clk),
	.reset        (reset),
	.sampleStrobe (sampleStrobe),
	.resultValid  (resultValid),
	.classIdx     (classIdx)
);

//--- nnClassifier.sv
`timescale 1ns/1ps

module nnClassifier (
	input  logic               clk,
	input  logic               reset,
	input  nnPkg::featureVec_t features,
	input  logic               sampleStrobe,
	output nnPkg::classIdx_t   classIdx,
	output nnPkg::sample_t     classScore,
	output logic               resultValid
);
	import nnPkg::*;

	hiddenVec_t hiddenAct;
	logic       hiddenValid;
	classVec_t  classAct;
	logic       classValid;

	// ------------------------------------------------------------------------
	// Hidden layer, 15 features in, 4 ReLU neurons out
	// ------------------------------------------------------------------------
	denseLayer #(
		.NUM_IN     (NUM_FEATURES),
		.NUM_OUT    (NUM_HIDDEN),
		.WEIGHTS    (HIDDEN_WEIGHTS),
		.BIASES     (HIDDEN_BIAS),
		.ACTIVATION (ACT_RELU)
	) u_hidden (
		.clk      (clk),
		.reset    (reset),
		.actIn    (features),
		.validIn  (sampleStrobe),
		.actOut   (hiddenAct),
		.validOut (hiddenValid)
	);

	// ------------------------------------------------------------------------
	// Output layer, linear
	// ------------------------------------------------------------------------
	denseLayer #(
		.NUM_IN     (NUM_HIDDEN),
		.NUM_OUT    (NUM_CLASSES),
		.WEIGHTS    (OUTPUT_WEIGHTS),
		.BIASES     (OUTPUT_BIAS),
		.ACTIVATION (ACT_LINEAR)
	) u_output (
		.clk      (clk),
		.reset    (reset),
		.actIn    (hiddenAct),
		.validIn  (hiddenValid),
		.actOut   (classAct),
		.validOut (classValid)
	);

	argmaxSelect #(
		.NUM_IN (NUM_CLASSES)
	) u_argmax (
		.clk       (clk),
		.reset     (reset),
		.scores    (classAct),
		.validIn   (classValid),
		.bestIdx   (classIdx),
		.bestScore (classScore),
		.validOut  (resultValid)  // 7 cycles after sampleStrobe
	);

endmodule

//--- argmaxSelect.sv
`timescale 1ns/1ps

module argmaxSelect #(
	parameter int NUM_IN = nnPkg::NUM_CLASSES
) (
	input  logic                          clk,
	input  logic                          reset,
	input  nnPkg::sample_t [NUM_IN-1:0]   scores,
	input  logic                          validIn,
	output nnPkg::classIdx_t              bestIdx,
	output nnPkg::sample_t                bestScore,
	output logic                          validOut
);
	import nnPkg::*;

	classIdx_t scanIdx;
	sample_t   scanScore;

	// Linear scan over the class scores
	always_comb
	begin
		scanIdx   = '0;
		scanScore = scores[0];
		for (int i = 1; i < NUM_IN; i++)
		begin
			// Strictly greater, so the lower index keeps a tie
			if ($signed(scores[i]) > $signed(scanScore))
			begin
				scanIdx   = classIdx_t'(i);
				scanScore = scores[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			bestIdx   <= '0;
			bestScore <= '0;
			validOut  <= 1'b0;
		end
		else
		begin
			bestIdx   <= scanIdx;
			bestScore <= scanScore;
			validOut  <= validIn;
		end
	end

endmodule

//--- denseLayer.sv
`timescale 1ns/1ps

module denseLayer #(
	parameter int NUM_IN  = nnPkg::NUM_FEATURES,
	parameter int NUM_OUT = nnPkg::NUM_HIDDEN,
	parameter nnPkg::sample_t [NUM_OUT-1:0][NUM_IN-1:0] WEIGHTS = '0,
	parameter nnPkg::sample_t [NUM_OUT-1:0] BIASES = '0,
	parameter nnPkg::activation_t ACTIVATION = nnPkg::ACT_LINEAR
) (
	input  logic                          clk,
	input  logic                          reset,
	input  nnPkg::sample_t [NUM_IN-1:0]   actIn,
	input  logic                          validIn,
	output nnPkg::sample_t [NUM_OUT-1:0]  actOut,
	output logic                          validOut
);
	import nnPkg::*;

	logic [NODE_LATENCY-1:0] validPipe; // Bit 0 is the newest stage

	// ------------------------------------------------------------------------
	// Neurons
	// ------------------------------------------------------------------------
	// Every neuron sees the same input vector
	for (genvar n = 0; n < NUM_OUT; n++)
	begin : gNode
		neuronNode #(
			.NUM_IN     (NUM_IN),
			.WEIGHTS    (WEIGHTS[n]),
			.BIAS       (BIASES[n]),
			.ACTIVATION (ACTIVATION)
		) u_node (
			.clk    (clk),
			.reset  (reset),
			.act    (actIn),
			.result (actOut[n])
		);
	end

	// ------------------------------------------------------------------------
	// Strobe delay line
	// ------------------------------------------------------------------------
	// Matches the three register stages inside each neuron
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[NODE_LATENCY-2:0], validIn};
		end
	end

	assign validOut = validPipe[NODE_LATENCY-1];

endmodule

//--- neuronNode.sv
`timescale 1ns/1ps

module neuronNode #(
	parameter int NUM_IN = nnPkg::NUM_FEATURES,
	parameter nnPkg::sample_t [NUM_IN-1:0] WEIGHTS = '0,
	parameter nnPkg::sample_t BIAS = '0,
	parameter nnPkg::activation_t ACTIVATION = nnPkg::ACT_RELU
) (
	input  logic                          clk,
	input  logic                          reset,
	input  nnPkg::sample_t [NUM_IN-1:0]   act,
	output nnPkg::sample_t                result
);
	import nnPkg::*;

	sample_t [NUM_IN-1:0] actReg;   // Stage 1
	sample_t [NUM_IN-1:0] product;
	sample_t              sumNext;
	sample_t              sumReg;   // Stage 2
	logic                 clipSum;

	// ------------------------------------------------------------------------
	// Multiply-accumulate, all in 8 bits
	// ------------------------------------------------------------------------
	always_comb
	begin
		for (int i = 0; i < NUM_IN; i++)
		begin
			product[i] = sample_t'(actReg[i] * WEIGHTS[i]); // Low byte of the product
		end
	end

	always_comb
	begin
		sumNext = BIAS;
		for (int i = 0; i < NUM_IN; i++)
		begin
			sumNext = sumNext + product[i]; // Wraps modulo 256
		end
	end

	// ReLU only looks at the sign bit
	assign clipSum = (ACTIVATION == ACT_RELU) && sumReg[DATA_W-1];

	// ------------------------------------------------------------------------
	// Pipeline registers
	// ------------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actReg <= '0;
			sumReg <= '0;
			result <= '0;
		end
		else
		begin
			actReg <= act;
			sumReg <= sumNext;
			if (clipSum)
			begin
				result <= '0;
			end
			else
			begin
				result <= sumReg; // Stage 3
			end
		end
	end

endmodule

//--- nnPkg.sv
package nnPkg;

	// ------------------------------------------------------------------------
	// Sizes
	// ------------------------------------------------------------------------
	localparam int DATA_W       = 8;
	localparam int NUM_FEATURES = 15;
	localparam int NUM_HIDDEN   = 4;
	localparam int NUM_CLASSES  = 3;
	localparam int NODE_LATENCY = 3; // Input, sum and activation registers

	typedef enum logic
	{
		ACT_RELU   = 1'b0,
		ACT_LINEAR = 1'b1
	} activation_t;

	typedef logic signed [DATA_W-1:0] sample_t;

	typedef sample_t [NUM_HIDDEN-1:0]   hiddenVec_t;
	typedef sample_t [NUM_CLASSES-1:0]  classVec_t;
	typedef sample_t [NUM_FEATURES-1:0] featureVec_t;
	typedef logic [1:0]                 classIdx_t;

	typedef featureVec_t [NUM_HIDDEN-1:0] hiddenWeights_t;  // One row per hidden neuron
	typedef hiddenVec_t [NUM_CLASSES-1:0] outputWeights_t;  // One row per class

	// ------------------------------------------------------------------------
	// Fixed network constants
	// Each concatenation lists the highest index first, so row 0 and
	// weight 0 sit at the end of their lists
	// ------------------------------------------------------------------------
	localparam hiddenWeights_t HIDDEN_WEIGHTS = {
		{-8'sd19, 8'sd25, 8'sd3, -8'sd58, 8'sd16, 8'sd44, -8'sd35,
		 -8'sd13, 8'sd20, -8'sd4, 8'sd31, 8'sd48, -8'sd26, -8'sd15, 8'sd7},
		{8'sd10, -8'sd29, 8'sd36, 8'sd22, -8'sd7, 8'sd14, 8'sd51, -8'sd40,
		 -8'sd18, 8'sd27, 8'sd9, -8'sd45, 8'sd12, 8'sd33, -8'sd6},
		{8'sd2, 8'sd19, -8'sd27, -8'sd11, 8'sd64, 8'sd5, -8'sd21, 8'sd30,
		 8'sd8, -8'sd52, 8'sd17, -8'sd3, 8'sd41, -8'sd9, 8'sd23},
		// Neuron 0
		{-8'sd45, -8'sd16, 8'sd11, 8'sd78, -8'sd37, -8'sd38, 8'sd3, 8'sd13,
		 -8'sd64, 8'sd36, -8'sd17, 8'sd55, -8'sd84, 8'sd11, 8'sd14}
	};

	// Non-positive so an all-zero input leaves every hidden neuron at zero
	localparam hiddenVec_t HIDDEN_BIAS = {-8'sd2, -8'sd9, -8'sd4, 8'sd0};

	localparam outputWeights_t OUTPUT_WEIGHTS = {
		{8'sd13, -8'sd17, 8'sd5, 8'sd11},
		{-8'sd6, 8'sd14, 8'sd21, -8'sd9},
		{8'sd25, 8'sd7, -8'sd12, 8'sd18}
	};

	localparam classVec_t OUTPUT_BIAS = {8'sd12, -8'sd3, 8'sd5};

endpackage
